//--- alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// scalar datapath width
`define ALU_W 32

// packed simd and result width
`define SIMD_W 64

// opcode field and number of defined operations
`define OP_W 5
`define OP_COUNT 19

// operand size field
`define SIZE_W 2

// adder constant select field
`define IMM_SEL_W 3

// shift count as carried in the request
`define SHCNT_W 8

// in-range shifts, 0 to 31, use 5 bits
`define SHF_IDX_W 5
`define SHF_MAX 31

`endif

//--- alu_pkg.sv
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

    // operation codes, same order as the aluk field
    typedef enum logic [`OP_W-1:0] {
        OP_AND       = 5'd0,
        OP_ADD       = 5'd1,
        OP_BSF       = 5'd2,
        OP_MOVB      = 5'd3,
        OP_MOVA      = 5'd4,
        OP_CLD       = 5'd5,
        OP_STD       = 5'd6,
        OP_CMPXCHG   = 5'd7,
        OP_DAA       = 5'd8,
        OP_NOT       = 5'd9,
        OP_OR        = 5'd10,
        OP_PADDW     = 5'd11,
        OP_PADDD     = 5'd12,
        OP_PACKSSWB  = 5'd13,
        OP_PACKSSDW  = 5'd14,
        OP_PUNPCKHBW = 5'd15,
        OP_PUNPCKHWD = 5'd16,
        OP_SAR       = 5'd17,
        OP_SAL       = 5'd18
    } alu_op_t;

    typedef enum logic [`SIZE_W-1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2,
        SZ_QWORD = 2'd3
    } opsize_t;

    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
        logic df;
    } flags_t;

    // raw request from decode
    typedef struct packed {
        alu_op_t              op;
        logic [`SIMD_W-1:0]   op1;
        logic [`SIMD_W-1:0]   op2;
        logic [`SIMD_W-1:0]   op3;
        logic [`ALU_W-1:0]    op1_orig;
        opsize_t              size;
        logic [`IMM_SEL_W-1:0] imm_sel;
        logic                 and_mask_sel;
        logic                 shf_one;
        flags_t               flags_in;
    } alu_req_t;

    // operands after constant and count selection
    typedef struct packed {
        alu_op_t             op;
        opsize_t             size;
        logic [`SIMD_W-1:0]  op1;
        logic [`SIMD_W-1:0]  b;
        logic [`SIMD_W-1:0]  op3;
        logic [`ALU_W-1:0]   op1_orig;
        logic [`SHCNT_W-1:0] shcnt;
        flags_t              flags_in;
    } alu_opnd_t;

    typedef struct packed {
        logic [`SIMD_W-1:0] result;
        logic [`SIMD_W-1:0] result2;
        logic [`ALU_W-1:0]  dest;
        logic               swap;
        logic               cf;
        logic               af;
        logic               of;
    } int_res_t;

    typedef struct packed {
        logic [`SIMD_W-1:0] result;
        logic               cf;
        logic               af;
        logic               of;
    } simd_res_t;

    typedef struct packed {
        logic bsf_zero;
        logic cmp_eq;
        logic shf_zero;
    } int_zero_t;

    typedef struct packed {
        logic [`SIMD_W-1:0] result;
        logic [`SIMD_W-1:0] result2;
        flags_t             flags;
        logic [`ALU_W-1:0]  dest;
        logic               swap;
        logic               cc_inval;
    } alu_res_t;

endpackage

`default_nettype wire

//--- alu_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module alu_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload holds between items
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- alu_operand_sel.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_operand_sel import alu_pkg::*; (
    input  alu_req_t  req,
    output alu_opnd_t opnd
);

    localparam logic [`SIMD_W-1:0] AND_MASK = 64'h0000_0000_0000_FFFF;

    logic [`SIMD_W-1:0] add_const;

    // adder constants, negative ones sign extended
    always_comb begin
        case (req.imm_sel)
            3'd0:    add_const = req.op2;
            3'd1:    add_const = 64'd2;
            3'd2:    add_const = 64'd4;
            3'd3:    add_const = 64'd6;
            3'd4:    add_const = 64'hFFFF_FFFF_FFFF_FFFE;
            3'd5:    add_const = 64'hFFFF_FFFF_FFFF_FFFC;
            default: add_const = '0;
        endcase
    end

    always_comb begin
        opnd.op       = req.op;
        opnd.size     = req.size;
        opnd.op1      = req.op1;
        opnd.op3      = req.op3;
        opnd.op1_orig = req.op1_orig;
        opnd.flags_in = req.flags_in;
        opnd.b        = req.op2;
        opnd.shcnt    = req.op2[`SHCNT_W-1:0];

        case (req.op)
            OP_ADD: begin
                opnd.b = add_const;
            end
            OP_AND: begin
                if (req.and_mask_sel) begin
                    opnd.b = AND_MASK;
                end
            end
            OP_SAR, OP_SAL: begin
                // single-bit shift form
                if (req.shf_one) begin
                    opnd.shcnt = 8'd1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- alu_int_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_int_unit import alu_pkg::*; (
    input  alu_opnd_t          opnd,
    output logic [`SIMD_W-1:0] result,
    output logic [`SIMD_W-1:0] result2,
    output logic               cf,
    output logic               af,
    output logic               of,
    output logic               swap,
    output logic [`ALU_W-1:0]  dest,
    output logic               bsf_zero,
    output logic               cmp_eq,
    output logic               shf_zero
);

    localparam int MSB = `ALU_W - 1;

    logic [`ALU_W-1:0]     a;
    logic [`ALU_W-1:0]     b;
    logic [`ALU_W:0]       sum;
    logic [`ALU_W:0]       diff;
    logic [`SHF_IDX_W-1:0] bsf_idx;
    logic [7:0]            daa_al;
    logic                  daa_af;
    logic                  daa_cf;
    logic                  shf_over;
    logic [`SHF_IDX_W-1:0] cnt;
    logic [`ALU_W-1:0]     sar_val;
    logic [`ALU_W-1:0]     sal_val;
    logic [`ALU_W-1:0]     sar_pre;
    logic [`ALU_W-1:0]     sal_pre;

    assign a        = opnd.op1[`ALU_W-1:0];
    assign b        = opnd.b[`ALU_W-1:0];
    assign sum      = {1'b0, a} + {1'b0, b};
    assign diff     = {1'b0, a} - {1'b0, b};
    assign cmp_eq   = a == opnd.op3[`ALU_W-1:0];
    assign bsf_zero = a == '0;

    ////////////////////////////////////////
    // shifter
    ////////////////////////////////////////

    assign shf_zero = opnd.shcnt == '0;
    assign shf_over = opnd.shcnt > `SHF_MAX;
    assign cnt      = opnd.shcnt[`SHF_IDX_W-1:0];
    assign sar_val  = $signed(a) >>> cnt;
    assign sal_val  = a << cnt;
    // one step short, exposes the last bit shifted out
    assign sar_pre  = a >> (cnt - 1'b1);
    assign sal_pre  = a << (cnt - 1'b1);

    // lowest set bit wins
    always_comb begin
        bsf_idx = '0;
        for (int i = MSB; i >= 0; i--) begin
            if (a[i]) begin
                bsf_idx = i[`SHF_IDX_W-1:0];
            end
        end
    end

    // decimal adjust of al after add
    always_comb begin
        daa_af = (a[3:0] > 4'd9) | opnd.flags_in.af;
        daa_cf = (a[7:0] > 8'h99) | opnd.flags_in.cf;
        daa_al = a[7:0];
        if (daa_af) begin
            daa_al = daa_al + 8'h06;
        end
        if (daa_cf) begin
            daa_al = daa_al + 8'h60;
        end
    end

    ////////////////////////////////////////
    // result and arithmetic flags
    ////////////////////////////////////////

    always_comb begin
        result = '0;
        cf     = 1'b0;
        af     = 1'b0;
        of     = 1'b0;
        case (opnd.op)
            OP_AND:  result = opnd.op1 & opnd.b;
            OP_OR:   result = opnd.op1 | opnd.b;
            OP_NOT:  result = ~opnd.op1;
            OP_MOVA: result = opnd.op1;
            OP_MOVB: result = opnd.b;
            OP_STD:  result = 64'd1;
            OP_BSF:  result[`SHF_IDX_W-1:0] = bsf_idx;
            OP_ADD: begin
                result[MSB:0] = sum[MSB:0];
                cf = sum[`ALU_W];
                af = a[4] ^ b[4] ^ sum[4];
                of = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            end
            OP_CMPXCHG: begin
                result[MSB:0] = cmp_eq ? b : a;
                // flags of the compare, op1 minus op2
                cf = diff[`ALU_W];
                af = a[4] ^ b[4] ^ diff[4];
                of = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
            end
            OP_DAA: begin
                result[7:0] = daa_al;
                cf = daa_cf;
                af = daa_af;
            end
            OP_SAR: begin
                cf = opnd.flags_in.cf;
                of = opnd.flags_in.of;
                if (shf_zero) begin
                    result[MSB:0] = a;
                end else if (shf_over) begin
                    result[MSB:0] = {`ALU_W{a[MSB]}};
                    cf = a[MSB];
                end else begin
                    result[MSB:0] = sar_val;
                    cf = sar_pre[0];
                    if (cnt == 5'd1) begin
                        of = 1'b0;
                    end
                end
            end
            OP_SAL: begin
                cf = opnd.flags_in.cf;
                of = opnd.flags_in.of;
                if (shf_zero) begin
                    result[MSB:0] = a;
                end else if (shf_over) begin
                    cf = 1'b0;
                end else begin
                    result[MSB:0] = sal_val;
                    cf = sal_pre[MSB];
                    if (cnt == 5'd1) begin
                        of = sal_val[MSB] ^ sal_pre[MSB];
                    end
                end
            end
            default: ;
        endcase
    end

    assign result2 = opnd.op1;
    assign swap    = (opnd.op == OP_CMPXCHG) && cmp_eq;
    assign dest    = (opnd.op != OP_CMPXCHG) ? opnd.op1_orig :
                     cmp_eq ? opnd.op1_orig : '0;

endmodule

`default_nettype wire

//--- alu_simd_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_simd_unit import alu_pkg::*; (
    input  alu_opnd_t          opnd,
    output logic [`SIMD_W-1:0] result
);

    // signed word to byte, clamped at the limits
    function automatic logic [7:0] sat_w2b(input logic [15:0] w);
        if ($signed(w) > 16'sd127) begin
            return 8'h7F;
        end else if ($signed(w) < -16'sd128) begin
            return 8'h80;
        end
        return w[7:0];
    endfunction

    function automatic logic [15:0] sat_d2w(input logic [31:0] d);
        if ($signed(d) > 32'sd32767) begin
            return 16'h7FFF;
        end else if ($signed(d) < -32'sd32768) begin
            return 16'h8000;
        end
        return d[15:0];
    endfunction

    always_comb begin
        result = '0;
        case (opnd.op)
            OP_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    result[16*i +: 16] = opnd.op1[16*i +: 16] + opnd.b[16*i +: 16];
                end
            end
            OP_PADDD: begin
                for (int i = 0; i < 2; i++) begin
                    result[32*i +: 32] = opnd.op1[32*i +: 32] + opnd.b[32*i +: 32];
                end
            end
            // op1 lanes fill the low half, op2 lanes the high half
            OP_PACKSSWB: begin
                for (int i = 0; i < 4; i++) begin
                    result[8*i +: 8]      = sat_w2b(opnd.op1[16*i +: 16]);
                    result[8*i + 32 +: 8] = sat_w2b(opnd.b[16*i +: 16]);
                end
            end
            OP_PACKSSDW: begin
                for (int i = 0; i < 2; i++) begin
                    result[16*i +: 16]      = sat_d2w(opnd.op1[32*i +: 32]);
                    result[16*i + 32 +: 16] = sat_d2w(opnd.b[32*i +: 32]);
                end
            end
            OP_PUNPCKHBW: begin
                for (int i = 0; i < 4; i++) begin
                    result[16*i +: 8]     = opnd.op1[32 + 8*i +: 8];
                    result[16*i + 8 +: 8] = opnd.b[32 + 8*i +: 8];
                end
            end
            OP_PUNPCKHWD: begin
                for (int i = 0; i < 2; i++) begin
                    result[32*i +: 16]      = opnd.op1[32 + 16*i +: 16];
                    result[32*i + 16 +: 16] = opnd.b[32 + 16*i +: 16];
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- alu_flag_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_flag_gen import alu_pkg::*; (
    input  alu_opnd_t opnd,
    input  int_res_t  int_res,
    input  simd_res_t simd_res,
    input  int_zero_t int_zero_info,
    output alu_res_t  res
);

    logic               is_simd;
    logic               is_shift;
    logic               int_flags;
    logic [`SIMD_W-1:0] value;

    assign is_simd   = opnd.op inside {OP_PADDW, OP_PADDD, OP_PACKSSWB, OP_PACKSSDW,
                                       OP_PUNPCKHBW, OP_PUNPCKHWD};
    assign is_shift  = opnd.op inside {OP_SAR, OP_SAL};
    // ops whose cf, af and of are produced
    assign int_flags = is_shift || (opnd.op inside {OP_ADD, OP_DAA, OP_CMPXCHG});
    assign value     = is_simd ? simd_res.result : int_res.result;

    always_comb begin
        res.result   = value;
        res.result2  = int_res.result2;
        res.dest     = int_res.dest;
        res.swap     = int_res.swap;
        res.cc_inval = is_shift && int_zero_info.shf_zero;

        // sign bit at the operand size
        case (opnd.size)
            SZ_BYTE:  res.flags.sf = value[7];
            SZ_WORD:  res.flags.sf = value[15];
            SZ_DWORD: res.flags.sf = value[31];
            default:  res.flags.sf = value[63];
        endcase

        case (opnd.op)
            OP_BSF:     res.flags.zf = int_zero_info.bsf_zero;
            OP_CMPXCHG: res.flags.zf = int_zero_info.cmp_eq;
            default:    res.flags.zf = value == '0;
        endcase

        res.flags.pf = ~^value[7:0];

        res.flags.df = opnd.flags_in.df;
        if (opnd.op == OP_CLD) begin
            res.flags.df = 1'b0;
        end else if (opnd.op == OP_STD) begin
            res.flags.df = 1'b1;
        end

        res.flags.cf = 1'b0;
        res.flags.af = 1'b0;
        res.flags.of = 1'b0;
        if (is_simd) begin
            res.flags.cf = simd_res.cf;
            res.flags.af = simd_res.af;
            res.flags.of = simd_res.of;
        end else if (int_flags) begin
            res.flags.cf = int_res.cf;
            res.flags.af = int_res.af;
            res.flags.of = int_res.of;
        end
    end

endmodule

`default_nettype wire

//--- alu_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec_top import alu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  alu_req_t in_req,
    output logic     out_valid,
    output alu_res_t out_res
);

    alu_opnd_t opnd_d;
    alu_opnd_t opnd_q;
    logic      s1_valid;
    int_res_t  int_res;
    simd_res_t simd_res;
    int_zero_t int_zero;
    alu_res_t  res_d;

    ////////////////////////////////////////
    // stage 1, operand prep
    ////////////////////////////////////////

    alu_operand_sel u_operand_sel (
        .req  (in_req),
        .opnd (opnd_d)
    );

    alu_stage_reg #(.payload_t(alu_opnd_t)) s1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (opnd_d),
        .out_valid (s1_valid),
        .out_data  (opnd_q)
    );

    ////////////////////////////////////////
    // stage 2, execute and flags
    ////////////////////////////////////////

    alu_int_unit u_int_unit (
        .opnd     (opnd_q),
        .result   (int_res.result),
        .result2  (int_res.result2),
        .cf       (int_res.cf),
        .af       (int_res.af),
        .of       (int_res.of),
        .swap     (int_res.swap),
        .dest     (int_res.dest),
        .bsf_zero (int_zero.bsf_zero),
        .cmp_eq   (int_zero.cmp_eq),
        .shf_zero (int_zero.shf_zero)
    );

    alu_simd_unit u_simd_unit (
        .opnd   (opnd_q),
        .result (simd_res.result)
    );

    // packed ops leave cf, af and of clear
    assign {simd_res.cf, simd_res.af, simd_res.of} = 3'b000;

    alu_flag_gen u_flag_gen (
        .opnd          (opnd_q),
        .int_res       (int_res),
        .simd_res      (simd_res),
        .int_zero_info (int_zero),
        .res           (res_d)
    );

    alu_stage_reg #(.payload_t(alu_res_t)) s2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s1_valid),
        .in_data   (res_d),
        .out_valid (out_valid),
        .out_data  (out_res)
    );

endmodule

`default_nettype wire

//--- tb_alu_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module tb_alu_scoreboard import alu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  alu_req_t in_req,
    input  logic     out_valid,
    input  alu_res_t out_res,
    output int       mismatches,
    output int       protocol_errs,
    output int       pending
);

    alu_res_t exp_q[$];
    alu_op_t  op_q[$];

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v > hi) begin
            return hi;
        end
        if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic alu_res_t expected_result(input alu_req_t r);
        alu_res_t    e;
        logic [63:0] b;
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] t;
        logic [31:0] sat;
        logic [32:0] wide;
        logic [4:0]  nib;
        logic [7:0]  cnt;
        logic [7:0]  al;
        logic        eq;
        longint      sa;
        longint      sb;
        int          k;
        e   = '0;
        a32 = r.op1[31:0];
        b   = r.op2;
        cnt = r.shf_one ? 8'd1 : r.op2[7:0];
        eq  = a32 == r.op3[31:0];
        if (r.op == OP_ADD) begin
            case (r.imm_sel)
                3'd0:    b = r.op2;
                3'd1:    b = 64'd2;
                3'd2:    b = 64'd4;
                3'd3:    b = 64'd6;
                3'd4:    b = -64'd2;
                3'd5:    b = -64'd4;
                default: b = '0;
            endcase
        end else if (r.op == OP_AND && r.and_mask_sel) begin
            b = 64'hFFFF;
        end
        b32        = b[31:0];
        sa         = $signed(a32);
        sb         = $signed(b32);
        e.result2  = r.op1;
        e.dest     = r.op1_orig;
        e.flags.df = r.flags_in.df;

        case (r.op)
            OP_AND:  e.result = r.op1 & b;
            OP_OR:   e.result = r.op1 | b;
            OP_NOT:  e.result = ~r.op1;
            OP_MOVA: e.result = r.op1;
            OP_MOVB: e.result = b;
            OP_CLD:  e.flags.df = 1'b0;
            OP_STD: begin
                e.result   = 64'd1;
                e.flags.df = 1'b1;
            end
            OP_BSF: begin
                k = 0;
                while (k < 32 && !a32[k]) begin
                    k++;
                end
                e.result = (k < 32) ? 64'(k) : 64'd0;
            end
            OP_ADD: begin
                wide       = a32 + b32;
                nib        = a32[3:0] + b32[3:0];
                e.result   = {32'b0, wide[31:0]};
                e.flags.cf = wide[32];
                e.flags.af = nib[4];
                e.flags.of = (sa + sb) != longint'($signed(wide[31:0]));
            end
            OP_CMPXCHG: begin
                t          = a32 - b32;
                e.result   = eq ? {32'b0, b32} : {32'b0, a32};
                e.swap     = eq;
                e.dest     = eq ? r.op1_orig : '0;
                e.flags.cf = a32 < b32;
                e.flags.af = a32[3:0] < b32[3:0];
                e.flags.of = (sa - sb) != longint'($signed(t));
            end
            OP_DAA: begin
                al = a32[7:0];
                if (al[3:0] > 4'd9 || r.flags_in.af) begin
                    al         = al + 8'h06;
                    e.flags.af = 1'b1;
                end
                if (a32[7:0] > 8'h99 || r.flags_in.cf) begin
                    al         = al + 8'h60;
                    e.flags.cf = 1'b1;
                end
                e.result = {56'b0, al};
            end
            OP_SAR, OP_SAL: begin
                e.flags.cf = r.flags_in.cf;
                e.flags.of = r.flags_in.of;
                if (cnt == 8'd0) begin
                    t = a32;
                end else if (cnt > 8'd31) begin
                    // every bit shifted out
                    t          = (r.op == OP_SAR) ? {32{a32[31]}} : '0;
                    e.flags.cf = (r.op == OP_SAR) ? a32[31] : 1'b0;
                end else if (r.op == OP_SAR) begin
                    t          = $signed(a32) >>> cnt;
                    e.flags.cf = a32[cnt - 1];
                    if (cnt == 8'd1) begin
                        e.flags.of = 1'b0;
                    end
                end else begin
                    t          = a32 << cnt;
                    e.flags.cf = a32[32 - cnt];
                    if (cnt == 8'd1) begin
                        e.flags.of = t[31] ^ e.flags.cf;
                    end
                end
                e.result = {32'b0, t};
            end
            OP_PADDW: begin
                for (k = 0; k < 4; k++) begin
                    e.result[16*k +: 16] = r.op1[16*k +: 16] + r.op2[16*k +: 16];
                end
            end
            OP_PADDD: begin
                for (k = 0; k < 2; k++) begin
                    e.result[32*k +: 32] = r.op1[32*k +: 32] + r.op2[32*k +: 32];
                end
            end
            OP_PACKSSWB: begin
                for (k = 0; k < 4; k++) begin
                    sat = clamp($signed(r.op1[16*k +: 16]), -128, 127);
                    e.result[8*k +: 8] = sat[7:0];
                    sat = clamp($signed(r.op2[16*k +: 16]), -128, 127);
                    e.result[32 + 8*k +: 8] = sat[7:0];
                end
            end
            OP_PACKSSDW: begin
                for (k = 0; k < 2; k++) begin
                    sat = clamp($signed(r.op1[32*k +: 32]), -32768, 32767);
                    e.result[16*k +: 16] = sat[15:0];
                    sat = clamp($signed(r.op2[32*k +: 32]), -32768, 32767);
                    e.result[32 + 16*k +: 16] = sat[15:0];
                end
            end
            OP_PUNPCKHBW: begin
                for (k = 0; k < 4; k++) begin
                    e.result[16*k +: 8]     = r.op1[32 + 8*k +: 8];
                    e.result[16*k + 8 +: 8] = r.op2[32 + 8*k +: 8];
                end
            end
            OP_PUNPCKHWD: begin
                for (k = 0; k < 2; k++) begin
                    e.result[32*k +: 16]      = r.op1[32 + 16*k +: 16];
                    e.result[32*k + 16 +: 16] = r.op2[32 + 16*k +: 16];
                end
            end
            default: ;
        endcase

        case (r.size)
            SZ_BYTE:  e.flags.sf = e.result[7];
            SZ_WORD:  e.flags.sf = e.result[15];
            SZ_DWORD: e.flags.sf = e.result[31];
            default:  e.flags.sf = e.result[63];
        endcase
        if (r.op == OP_BSF) begin
            e.flags.zf = a32 == '0;
        end else if (r.op == OP_CMPXCHG) begin
            e.flags.zf = eq;
        end else begin
            e.flags.zf = e.result == '0;
        end
        e.flags.pf = ~^e.result[7:0];
        e.cc_inval = (r.op == OP_SAR || r.op == OP_SAL) && cnt == 8'd0;
        return e;
    endfunction

    ////////////////////////////////////////
    // queue and compare
    ////////////////////////////////////////

    always @(posedge clk) begin
        alu_res_t exp;
        alu_op_t  op;
        if (reset) begin
            exp_q.delete();
            op_q.delete();
            mismatches    = 0;
            protocol_errs = 0;
        end else begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("error: result came out with no request outstanding");
                    protocol_errs++;
                end else begin
                    exp = exp_q.pop_front();
                    op  = op_q.pop_front();
                    if (out_res !== exp) begin
                        $display("[FAIL] %s: expected %h, actual %h", op.name(), exp, out_res);
                        mismatches++;
                    end
                end
            end
            if (in_valid) begin
                exp_q.push_back(expected_result(in_req));
                op_q.push_back(in_req.op);
            end
        end
        pending <= exp_q.size();
    end

endmodule

`default_nettype wire

//--- alu_exec_chk.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec_chk (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic out_valid
);

    int fail_count = 0;

    // quiet through reset and one cycle past it
    a_quiet_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after a reset edge");
        end

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> ##1 !out_valid)
        else begin
            fail_count++;
            $error("out_valid high two cycles after a reset edge");
        end

    // fixed two-cycle latency
    a_valid_follows: assert property (@(posedge clk) disable iff (reset)
                                      in_valid |-> ##2 out_valid)
        else begin
            fail_count++;
            $error("accepted request gave no out_valid two cycles later");
        end

    a_no_extra_valid: assert property (@(posedge clk) disable iff (reset)
                                       !in_valid |-> ##2 !out_valid)
        else begin
            fail_count++;
            $error("out_valid high with no request two cycles earlier");
        end

endmodule

`default_nettype wire

//--- tb_alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module tb_alu_exec import alu_pkg::*; ();

    localparam int          N_REQ       = 2000;
    localparam int          CLK_NS      = 8;
    localparam int          WATCHDOG_NS = (N_REQ + 20) * CLK_NS * 2;
    localparam int          DRAIN_MAX   = 16;
    localparam logic [31:0] SEED        = 32'h1a668394;

    logic        clk;
    logic        reset;
    logic        in_valid;
    alu_req_t    in_req;
    logic        out_valid;
    alu_res_t    out_res;
    int          mismatches;
    int          protocol_errs;
    int          pending;
    logic [31:0] rng;

    alu_exec_top DUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    tb_alu_scoreboard u_scoreboard (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_req        (in_req),
        .out_valid     (out_valid),
        .out_res       (out_res),
        .mismatches    (mismatches),
        .protocol_errs (protocol_errs),
        .pending       (pending)
    );

    bind alu_exec_top alu_exec_chk u_chk (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .out_valid (out_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [63:0] next_rand64();
        logic [31:0] hi;
        hi = next_rand();
        return {hi, next_rand()};
    endfunction

    task automatic build_request(output alu_req_t r);
        logic [31:0] pick;
        r.op           = alu_op_t'(next_rand() % `OP_COUNT);
        r.op1          = next_rand64();
        r.op2          = next_rand64();
        r.op3          = next_rand64();
        r.op1_orig     = next_rand();
        pick           = next_rand();
        r.size         = opsize_t'(pick[1:0]);
        r.imm_sel      = pick[4:2];
        r.and_mask_sel = pick[5];
        r.shf_one      = pick[6] & pick[7];
        r.flags_in     = flags_t'(pick[14:8]);
        // steer some requests into the corner cases
        case (r.op)
            OP_SAR, OP_SAL: begin
                case (pick[17:16])
                    2'd0:    r.op2[7:0] = 8'd0;
                    2'd1:    r.op2[7:0] = 8'd1;
                    2'd2:    r.op2[7:0] = {3'b000, pick[22:18]};
                    default: ;
                endcase
            end
            OP_CMPXCHG: begin
                if (pick[16]) begin
                    r.op3[31:0] = r.op1[31:0];
                end
            end
            OP_BSF: begin
                if (pick[17:16] == 2'd0) begin
                    r.op1[31:0] = '0;
                end
            end
            // mix of in-range and saturating lanes
            OP_PACKSSWB, OP_PACKSSDW: begin
                if (pick[16]) begin
                    r.op1 = r.op1 & 64'h0000_7fff_ffff_007f;
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // stimulus and end of run
    ////////////////////////////////////////

    initial begin
        alu_req_t    req;
        logic [31:0] pick;
        int          sent;
        int          waited;
        int          leftover;
        int          total;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_req   = '0;
        rng      = SEED;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // about three in four cycles carry a request
        sent = 0;
        while (sent < N_REQ) begin
            @(posedge clk);
            pick = next_rand();
            if (pick[1:0] != 2'b00) begin
                build_request(req);
                in_req   <= req;
                in_valid <= 1'b1;
                sent++;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);

        waited = 0;
        while (pending != 0 && waited < DRAIN_MAX) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);

        leftover = pending;
        if (leftover != 0) begin
            $display("error: %0d requests never produced a result", leftover);
        end
        total = mismatches + protocol_errs + leftover + DUT.u_chk.fail_count;
        $display("errors: %0d mismatched, %0d protocol, %0d left over, %0d assertion",
                 mismatches, protocol_errs, leftover, DUT.u_chk.fail_count);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
alu_pkg.sv
alu_stage_reg.sv
alu_operand_sel.sv
alu_int_unit.sv
alu_simd_unit.sv
alu_flag_gen.sv
alu_exec_top.sv
tb_alu_scoreboard.sv
alu_exec_chk.sv
tb_alu_exec.sv

//--- Bender.yml
package:
  name: alu_exec

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - alu_pkg.sv
      - alu_stage_reg.sv
      - alu_operand_sel.sv
      - alu_int_unit.sv
      - alu_simd_unit.sv
      - alu_flag_gen.sv
      - alu_exec_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_alu_scoreboard.sv
      - alu_exec_chk.sv
      - tb_alu_exec.sv
